/* hdl/armAlu.sv */
`timescale 1ns/1ns
// ALU for ADD, SUB, AND and ORR with ARM-style N, Z, C, V outputs
module armAlu
(
   input  armPkg::word_t  a,
   input  armPkg::word_t  b,
   input  armPkg::aluOp_t op,
   output armPkg::word_t  result,
   output armPkg::flags_t flags
);
   import armPkg::*;

   logic        sub;
   logic        arith;
   word_t       bMux;
   logic [32:0] sum;

   assign sub   = (op == SUB);
   assign arith = (op == ADD) | sub;
   assign bMux  = sub ? ~b : b;                          // Two's complement subtract
   assign sum   = {1'b0, a} + {1'b0, bMux} + 33'(sub);

   always_comb
   begin
      case (op)
         AND:     result = a & b;
         ORR:     result = a | b;
         default: result = sum[31:0];
      endcase
   end

   assign flags[3] = result[31];
   assign flags[2] = (result == '0);
   assign flags[1] = arith & sum[32];   // Carry means no borrow on SUB
   // Operands of equal sign giving a result of the other sign
   assign flags[0] = arith & (a[31] ~^ bMux[31]) & (a[31] ^ sum[31]);

endmodule

/* hdl/armCondUnit.sv */
`timescale 1ns/1ns
// Execute-stage condition check with the N, Z, C, V flags register
module armCondUnit
(
   input  logic           clk,
   input  logic           reset,
   input  armPkg::cond_t  condE,
   input  logic [1:0]     flagWriteE,
   input  armPkg::flags_t aluFlagsE,
   input  logic           flushE,
   output logic           condExE
);
   import armPkg::*;

   flags_t flags;
   logic   n, z, c, v;
   logic   ge;
   logic   updateE;

   assign {n, z, c, v} = flags;
   assign ge = (n == v);

   always_comb
   begin
      case (condE)
         EQ:      condExE = z;
         NE:      condExE = ~z;
         CS:      condExE = c;
         CC:      condExE = ~c;
         MI:      condExE = n;
         PL:      condExE = ~n;
         VS:      condExE = v;
         VC:      condExE = ~v;
         HI:      condExE = c & ~z;
         LS:      condExE = ~c | z;
         GE:      condExE = ge;
         LT:      condExE = ~ge;
         GT:      condExE = ~z & ge;
         LE:      condExE = z | ~ge;
         AL:      condExE = 1'b1;
         default: condExE = 1'b0;   // 1111 reserved
      endcase
   end

   // Flushing cycles hold a load or branch in Execute, neither sets flags
   assign updateE = condExE & ~flushE;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         flags <= '0;
      else
      begin
         if (updateE & flagWriteE[1])
            flags[3:2] <= aluFlagsE[3:2];   // N, Z
         if (updateE & flagWriteE[0])
            flags[1:0] <= aluFlagsE[1:0];   // C, V
      end
   end

   // A flag-setting instruction never loads unknown flags
   knownFlags: assert property (@(posedge clk) disable iff (reset)
      updateE && (flagWriteE != 2'b00) |-> !$isunknown(aluFlagsE));

endmodule

/* hdl/armCore.sv */
`timescale 1ns/1ns
// Five-stage pipelined core for an ARMv4 subset
// PC, stage registers, forwarding and writeback muxes around the datapath units
module armCore
#(
   parameter int RegCount = 15
)
(
   input  logic          clk,
   input  logic          reset,
   output armPkg::word_t pcF,
   input  armPkg::word_t instrF,
   output logic          memWriteM,
   output armPkg::word_t aluOutM,
   output armPkg::word_t writeDataM,
   input  armPkg::word_t readDataM
);
   import armPkg::*;

   word_t      pcPlus4F;
   word_t      pcNextF;

   word_t      instrD;
   logic       validD;      // Cleared for flushed or reset slots
   ctrl_t      ctrlD;
   ctrl_t      ctrlLiveD;
   word_t      extImmD;
   word_t      rd1D, rd2D;
   regAddr_t   ra1D, ra2D, rdD;
   cond_t      condD;

   ctrl_t      ctrlE, ctrlGatedE;
   cond_t      condE;
   word_t      rd1E, rd2E, extImmE;
   regAddr_t   ra1E, ra2E, rdE;
   word_t      srcAE, srcBE, writeDataE, aluResultE;
   flags_t     aluFlagsE;
   logic       condExE;
   logic       branchTakenE;

   ctrl_t      ctrlM;
   regAddr_t   rdM;

   ctrl_t      ctrlW;
   regAddr_t   rdW;
   word_t      aluOutW, readDataW, resultW;

   logic [1:0] forwardAE, forwardBE;
   logic       stallF, stallD, flushD, flushE;

   function automatic word_t forwardMux(input logic [1:0] sel, input word_t regVal,
                                        input word_t memVal, input word_t wbVal);
      case (sel)
         2'b10:   return memVal;
         2'b01:   return wbVal;
         default: return regVal;
      endcase
   endfunction

   // Fetch
   assign pcPlus4F = pcF + 32'd4;
   assign pcNextF  = branchTakenE ? aluResultE : pcPlus4F;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         pcF <= PcReset;
      else if (!stallF)
         pcF <= pcNextF;
   end

   // Decode register, enable and clear
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         instrD <= '0;
         validD <= 1'b0;
      end
      else if (flushD)
      begin
         instrD <= '0;
         validD <= 1'b0;
      end
      else if (!stallD)
      begin
         instrD <= instrF;
         validD <= 1'b1;
      end
   end

   armDecoder dec0
   (
      .instrD  (instrD),
      .ctrlD   (ctrlD),
      .extImmD (extImmD),
      .ra1D    (ra1D),
      .ra2D    (ra2D),
      .rdD     (rdD),
      .condD   (condD)
   );

   assign ctrlLiveD = validD ? ctrlD : '0;

   // Fetch PC+4 is the Decode instruction's PC+8
   armRegFile #(.RegCount(RegCount)) rf0
   (
      .clk     (clk),
      .we      (ctrlW.regWrite),
      .ra1     (ra1D),
      .ra2     (ra2D),
      .wa      (rdW),
      .wd      (resultW),
      .pcPlus8 (pcPlus4F),
      .rd1     (rd1D),
      .rd2     (rd2D)
   );

   // Execute register, control part has clear
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         ctrlE <= '0;
         condE <= EQ;
      end
      else if (flushE)
      begin
         ctrlE <= '0;
         condE <= EQ;
      end
      else
      begin
         ctrlE <= ctrlLiveD;
         condE <= condD;
      end
   end

   always_ff @(posedge clk)
   begin
      rd1E    <= rd1D;
      rd2E    <= rd2D;
      extImmE <= extImmD;
      ra1E    <= ra1D;
      ra2E    <= ra2D;
      rdE     <= rdD;
   end

   assign srcAE      = forwardMux(forwardAE, rd1E, aluOutM, resultW);
   assign writeDataE = forwardMux(forwardBE, rd2E, aluOutM, resultW);
   assign srcBE      = ctrlE.aluSrc ? extImmE : writeDataE;

   armAlu alu0
   (
      .a      (srcAE),
      .b      (srcBE),
      .op     (ctrlE.aluOp),
      .result (aluResultE),
      .flags  (aluFlagsE)
   );

   armCondUnit cond0
   (
      .clk        (clk),
      .reset      (reset),
      .condE      (condE),
      .flagWriteE (ctrlE.flagWrite),
      .aluFlagsE  (aluFlagsE),
      .flushE     (flushE),
      .condExE    (condExE)
   );

   assign branchTakenE = ctrlE.branch & condExE;

   // Failed condition turns the instruction into a no-op
   always_comb
   begin
      ctrlGatedE          = ctrlE;
      ctrlGatedE.regWrite = ctrlE.regWrite & condExE;
      ctrlGatedE.memWrite = ctrlE.memWrite & condExE;
      ctrlGatedE.branch   = branchTakenE;
   end

   // Memory and Writeback registers
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         ctrlM <= '0;
         ctrlW <= '0;
      end
      else
      begin
         ctrlM <= ctrlGatedE;
         ctrlW <= ctrlM;
      end
   end

   always_ff @(posedge clk)
   begin
      aluOutM    <= aluResultE;
      writeDataM <= writeDataE;
      rdM        <= rdE;
      aluOutW    <= aluOutM;
      readDataW  <= readDataM;
      rdW        <= rdM;
   end

   assign memWriteM = ctrlM.memWrite;
   assign resultW   = ctrlW.memToReg ? readDataW : aluOutW;   // Load data or ALU result

   armHazardUnit hz0
   (
      .ra1D         (ra1D),
      .ra2D         (ra2D),
      .ra1E         (ra1E),
      .ra2E         (ra2E),
      .rdE          (rdE),
      .rdM          (rdM),
      .rdW          (rdW),
      .regWriteM    (ctrlM.regWrite),
      .regWriteW    (ctrlW.regWrite),
      .memToRegE    (ctrlE.memToReg),
      .branchTakenE (branchTakenE),
      .forwardAE    (forwardAE),
      .forwardBE    (forwardBE),
      .stallF       (stallF),
      .stallD       (stallD),
      .flushD       (flushD),
      .flushE       (flushE)
   );

endmodule

/* hdl/armDecoder.sv */
`timescale 1ns/1ns
// Decode-stage instruction decoder
// Turns op/funct fields into the control bundle, immediate and register numbers
module armDecoder
(
   input  armPkg::word_t    instrD,
   output armPkg::ctrl_t    ctrlD,
   output armPkg::word_t    extImmD,
   output armPkg::regAddr_t ra1D,
   output armPkg::regAddr_t ra2D,
   output armPkg::regAddr_t rdD,
   output armPkg::cond_t    condD
);
   import armPkg::*;

   logic [1:0] op;
   logic       sBit;      // S for data processing, L for load/store
   immSrc_t    immSrcD;

   assign op   = instrD[27:26];
   assign sBit = instrD[20];

   always_comb
   begin
      ctrlD   = '0;
      immSrcD = IMM8;
      case (op)
         2'b00:   // Data processing
         begin
            ctrlD.regWrite = 1'b1;
            ctrlD.aluSrc   = instrD[25];
            case (instrD[24:21])
               4'b0100: ctrlD.aluOp = ADD;
               4'b0010: ctrlD.aluOp = SUB;
               4'b0000: ctrlD.aluOp = AND;
               4'b1100: ctrlD.aluOp = ORR;
               default: ctrlD.aluOp = aluOp_t'(2'bxx);
            endcase
            ctrlD.flagWrite[1] = sBit;
            ctrlD.flagWrite[0] = sBit & (ctrlD.aluOp inside {ADD, SUB});  // Logic ops keep C/V
         end
         2'b01:   // LDR / STR
         begin
            immSrcD        = IMM12;
            ctrlD.aluSrc   = 1'b1;
            ctrlD.aluOp    = ADD;   // Base plus offset
            ctrlD.regWrite = sBit;
            ctrlD.memToReg = sBit;
            ctrlD.memWrite = ~sBit;
         end
         2'b10:   // B
         begin
            immSrcD      = BRANCH24;
            ctrlD.aluSrc = 1'b1;
            ctrlD.aluOp  = ADD;
            ctrlD.branch = 1'b1;
         end
         default: ctrlD = '0;   // Not supported, acts as a no-op
      endcase
   end

   always_comb
   begin
      case (immSrcD)
         IMM8:    extImmD = {24'b0, instrD[7:0]};
         IMM12:   extImmD = {20'b0, instrD[11:0]};
         default: extImmD = {{6{instrD[23]}}, instrD[23:0], 2'b00};  // Word offset
      endcase
   end

   assign ra1D  = ctrlD.branch ? R15 : instrD[19:16];               // Branch base is PC+8
   assign ra2D  = ctrlD.memWrite ? instrD[15:12] : instrD[3:0];     // STR reads Rd
   assign rdD   = instrD[15:12];
   assign condD = cond_t'(instrD[31:28]);

   always_comb
   begin
      if (op == 2'b00)
         assert #0 (!$isunknown(ctrlD.aluOp))
            else $error("Unsupported data-processing funct %b", instrD[24:21]);
   end

endmodule

/* hdl/armHazardUnit.sv */
`timescale 1ns/1ns
// Forwarding selects, load-use stall and branch flush for the pipeline
module armHazardUnit
(
   input  armPkg::regAddr_t ra1D,
   input  armPkg::regAddr_t ra2D,
   input  armPkg::regAddr_t ra1E,
   input  armPkg::regAddr_t ra2E,
   input  armPkg::regAddr_t rdE,
   input  armPkg::regAddr_t rdM,
   input  armPkg::regAddr_t rdW,
   input  logic             regWriteM,
   input  logic             regWriteW,
   input  logic             memToRegE,
   input  logic             branchTakenE,
   output logic [1:0]       forwardAE,
   output logic [1:0]       forwardBE,
   output logic             stallF,
   output logic             stallD,
   output logic             flushD,
   output logic             flushE
);
   logic ldrStall;

   // Memory stage result is newer, so it wins
   always_comb
   begin
      if (regWriteM && ra1E == rdM)
         forwardAE = 2'b10;
      else if (regWriteW && ra1E == rdW)
         forwardAE = 2'b01;
      else
         forwardAE = 2'b00;

      if (regWriteM && ra2E == rdM)
         forwardBE = 2'b10;
      else if (regWriteW && ra2E == rdW)
         forwardBE = 2'b01;
      else
         forwardBE = 2'b00;
   end

   assign ldrStall = memToRegE & ((ra1D == rdE) | (ra2D == rdE));   // Load data not ready yet

   assign stallF = ldrStall;
   assign stallD = ldrStall;
   assign flushD = branchTakenE;
   assign flushE = ldrStall | branchTakenE;   // Bubble or wrong-path instruction

   // A load and a taken branch never share Execute
   always_comb
   begin
      assert #0 (!(ldrStall && branchTakenE))
         else $error("Load-use stall during a taken branch");
   end

endmodule

/* hdl/armPkg.sv */
// Shared types and encodings for the pipelined ARMv4 subset core
// Widths, condition and ALU codes, and the control bundle that rides the pipeline
package armPkg;

   typedef logic [31:0] word_t;      // Data or address word
   typedef logic [3:0]  regAddr_t;   // Register number
   typedef logic [3:0]  flags_t;     // {N, Z, C, V}

   // Instruction condition field
   typedef enum logic [3:0]
   {
      EQ = 4'b0000,
      NE, CS, CC, MI, PL, VS, VC,
      HI, LS, GE, LT, GT, LE, AL
   } cond_t;

   typedef enum logic [1:0]
   {
      ADD = 2'b00,
      SUB = 2'b01,
      AND = 2'b10,
      ORR = 2'b11
   } aluOp_t;

   typedef enum logic [1:0]
   {
      IMM8     = 2'b00,   // Data-processing immediate
      IMM12    = 2'b01,   // Load/store offset
      BRANCH24 = 2'b10
   } immSrc_t;

   // Control bits carried from Decode through Writeback
   typedef struct packed
   {
      logic       regWrite;
      logic       memWrite;
      logic       memToReg;
      logic       branch;
      logic       aluSrc;      // Immediate as ALU operand B
      aluOp_t     aluOp;
      logic [1:0] flagWrite;   // [1] N/Z, [0] C/V
   } ctrl_t;

   localparam word_t    PcReset = '0;
   localparam regAddr_t R15     = 4'd15;

endpackage

/* hdl/armRegFile.sv */
`timescale 1ns/1ns
// General register file, written on the falling edge, R15 reads as PC+8
module armRegFile
#(
   parameter int RegCount = 15
)
(
   input  logic             clk,
   input  logic             we,
   input  armPkg::regAddr_t ra1,
   input  armPkg::regAddr_t ra2,
   input  armPkg::regAddr_t wa,
   input  armPkg::word_t    wd,
   input  armPkg::word_t    pcPlus8,
   output armPkg::word_t    rd1,
   output armPkg::word_t    rd2
);
   import armPkg::*;

   word_t regs [RegCount];

   // Mid-cycle write so Decode sees the Writeback value in the same cycle
   always_ff @(negedge clk)
   begin
      if (we)
         regs[wa] <= wd;
   end

   assign rd1 = (ra1 == R15) ? pcPlus8 : regs[ra1];
   assign rd2 = (ra2 == R15) ? pcPlus8 : regs[ra2];

   noPcWrite: assert property (@(negedge clk) we |-> wa != R15);

endmodule

/* project.f */
hdl/armPkg.sv
hdl/armDecoder.sv
hdl/armCondUnit.sv
hdl/armRegFile.sv
hdl/armAlu.sv
hdl/armHazardUnit.sv
hdl/armCore.sv
testbench/armTestMem.sv
testbench/armCoreTb.sv

/* testbench/armCoreTb.sv */
`timescale 1ns/1ns
// Testbench for the pipelined core
// Builds a program in the test ROM and checks every store against a table of expected values
module armCoreTb;
   import armPkg::*;

   localparam int         RegCount      = 15;
   localparam int         MaxStores     = 32;
   localparam int         TimeoutCycles = 400;
   localparam logic [3:0] OpAdd         = 4'b0100;
   localparam logic [3:0] OpSub         = 4'b0010;
   localparam logic [3:0] OpAnd         = 4'b0000;
   localparam logic [3:0] OpOrr         = 4'b1100;

   logic  clk;
   logic  reset;
   word_t pcF, instrF, readDataM, aluOutM, writeDataM;
   logic  memWriteM;

   word_t expAddr [MaxStores];
   word_t expData [MaxStores];
   int    expCount = 0;
   int    storeIdx = 0;
   int    progLen  = 0;
   word_t nextOff  = 32'h100;   // Store offsets from R0

   armCore #(.RegCount(RegCount)) dut0
   (
      .clk        (clk),
      .reset      (reset),
      .pcF        (pcF),
      .instrF     (instrF),
      .memWriteM  (memWriteM),
      .aluOutM    (aluOutM),
      .writeDataM (writeDataM),
      .readDataM  (readDataM)
   );

   armTestMem mem0
   (
      .clk       (clk),
      .pc        (pcF),
      .instr     (instrF),
      .memWrite  (memWriteM),
      .addr      (aluOutM),
      .writeData (writeDataM),
      .readData  (readDataM)
   );

   function automatic word_t dataProcImm(input cond_t cond, input logic [3:0] opc,
                                         input logic s, input regAddr_t rn,
                                         input regAddr_t rd, input logic [7:0] imm);
      return {cond, 3'b001, opc, s, rn, rd, 4'b0000, imm};
   endfunction

   function automatic word_t dataProcReg(input cond_t cond, input logic [3:0] opc,
                                         input logic s, input regAddr_t rn,
                                         input regAddr_t rd, input regAddr_t rm);
      return {cond, 3'b000, opc, s, rn, rd, 8'h00, rm};
   endfunction

   // Pre-indexed with the offset added and no writeback
   function automatic word_t loadStore(input cond_t cond, input logic load, input regAddr_t rn,
                                       input regAddr_t rd, input logic [11:0] offset);
      return {cond, 2'b01, 5'b01100, load, rn, rd, offset};
   endfunction

   function automatic word_t branchTo(input cond_t cond, input logic [23:0] wordOffset);
      return {cond, 4'b1010, wordOffset};
   endfunction

   task automatic emit(input word_t instr);
      mem0.rom[progLen] = instr;
      progLen++;
   endtask

   // STR rd to the next free offset and list it as expected only if it should execute
   task automatic storeWord(input cond_t cond, input regAddr_t rd, input logic taken,
                            input word_t value);
      emit(loadStore(cond, 1'b0, 4'd0, rd, nextOff[11:0]));
      if (taken)
      begin
         expAddr[expCount] = nextOff;
         expData[expCount] = value;
         expCount++;
      end
      nextOff += 4;
   endtask

   // Conditional stores of R12 after SUBS R12 = x - y
   task automatic storeOnFlags(input word_t x, input word_t y);
      storeWord(EQ, 4'd12, x == y, x - y);
      storeWord(NE, 4'd12, x != y, x - y);
      storeWord(CS, 4'd12, x >= y, x - y);   // No borrow
      storeWord(LT, 4'd12, $signed(x) < $signed(y), x - y);
      storeWord(GT, 4'd12, $signed(x) > $signed(y), x - y);
   endtask

   task automatic buildProgram();
      word_t a, b, c, d, e;
      word_t loadVal;
      a       = $urandom % 256;
      b       = $urandom % 256;
      c       = $urandom % 256;
      d       = $urandom % 256;
      e       = $urandom % 256;
      loadVal = $urandom;
      for (int i = 0; i < 64; i++)
         mem0.rom[i] = branchTo(cond_t'(4'hF), 24'(i));   // Never executes
      for (int i = 0; i < 256; i++)
         mem0.ram[i] = {16'(i), ~16'(i)};
      mem0.ram[32'h200 >> 2] = loadVal;

      emit(dataProcReg(AL, OpSub, 1'b0, R15, 4'd0, R15));    // R0 = 0
      emit(dataProcImm(AL, OpAdd, 1'b0, 4'd0, 4'd1, a[7:0]));
      emit(dataProcImm(AL, OpAdd, 1'b0, 4'd0, 4'd2, b[7:0]));
      storeWord(AL, 4'd1, 1'b1, a);
      emit(dataProcReg(AL, OpAdd, 1'b0, 4'd1, 4'd3, 4'd2));
      storeWord(AL, 4'd3, 1'b1, a + b);                      // Data forwarded from Memory
      emit(dataProcImm(AL, OpSub, 1'b0, 4'd1, 4'd4, c[7:0]));
      emit(dataProcReg(AL, OpSub, 1'b0, 4'd3, 4'd5, 4'd2));
      storeWord(AL, 4'd4, 1'b1, a - c);
      storeWord(AL, 4'd5, 1'b1, a);
      emit(dataProcImm(AL, OpAnd, 1'b0, 4'd3, 4'd6, d[7:0]));
      emit(dataProcReg(AL, OpAnd, 1'b0, 4'd1, 4'd7, 4'd2));
      emit(dataProcImm(AL, OpOrr, 1'b0, 4'd6, 4'd8, e[7:0]));
      emit(dataProcReg(AL, OpOrr, 1'b0, 4'd7, 4'd9, 4'd3));
      storeWord(AL, 4'd6, 1'b1, (a + b) & d);
      storeWord(AL, 4'd7, 1'b1, a & b);
      storeWord(AL, 4'd8, 1'b1, ((a + b) & d) | e);
      storeWord(AL, 4'd9, 1'b1, (a & b) | (a + b));

      // Load followed at once by its use
      emit(loadStore(AL, 1'b1, 4'd0, 4'd10, 12'h200));
      emit(dataProcImm(AL, OpAdd, 1'b0, 4'd10, 4'd11, a[7:0]));
      storeWord(AL, 4'd11, 1'b1, loadVal + a);

      emit(dataProcReg(AL, OpSub, 1'b1, 4'd1, 4'd12, 4'd2));
      storeOnFlags(a, b);
      emit(dataProcReg(AL, OpSub, 1'b1, 4'd1, 4'd12, 4'd1));   // Equal operands
      storeOnFlags(a, a);

      emit(branchTo(NE, 24'd1));       // Z is set so this falls through
      storeWord(AL, 4'd1, 1'b1, a);
      emit(branchTo(AL, 24'd1));
      storeWord(AL, 4'd1, 1'b0, '0);   // Skipped pair
      storeWord(AL, 4'd2, 1'b0, '0);
      storeWord(AL, 4'd2, 1'b1, b);
      storeWord(AL, R15, 1'b1, word_t'(progLen * 4 + 8));
      emit(branchTo(AL, 24'hFFFFFE));  // Spin here
   endtask

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk)
   begin
      if (!reset && memWriteM)
         storeIdx <= storeIdx + 1;
   end

   storeMatches: assert property (@(posedge clk) disable iff (reset)
      memWriteM |-> (storeIdx < expCount && aluOutM == expAddr[storeIdx]
                     && writeDataM == expData[storeIdx]))
   else
   begin
      $display("ERR %0t: store %0d wrote %h to %h, expected %h to %h", $time,
               $sampled(storeIdx), $sampled(writeDataM), $sampled(aluOutM),
               expData[$sampled(storeIdx)], expAddr[$sampled(storeIdx)]);
      $display("Result: FAILED");
      $fatal(1, "Store check failed");
   end

   storeStrobeKnown: assert property (@(posedge clk) disable iff (reset)
      !$isunknown(memWriteM))
   else
   begin
      $display("ERR %0t: memWriteM is unknown", $time);
      $display("Result: FAILED");
      $fatal(1, "Unknown store strobe");
   end

   // The spin branch fetches at most two words past the last instruction
   fetchInProgram: assert property (@(posedge clk) disable iff (reset)
      pcF[1:0] == 2'b00 && pcF <= word_t'((progLen + 1) * 4))
   else
   begin
      $display("ERR %0t: fetch address %h lies outside the program", $time, $sampled(pcF));
      $display("Result: FAILED");
      $fatal(1, "Fetch address out of range");
   end

   initial
   begin
      int cycles;
      reset = 1'b1;
      void'($urandom(26373));
      buildProgram();
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      cycles = 0;
      while (storeIdx < expCount && cycles < TimeoutCycles)
      begin
         @(negedge clk);
         cycles++;
      end

      if (storeIdx < expCount)
      begin
         $display("Timeout: only %0d of %0d expected stores arrived", storeIdx, expCount);
         $display("Result: FAILED");
         $fatal(1, "Watchdog expired");
      end
      else
      begin
         repeat (10) @(negedge clk);   // Any extra store trips the check
         $display("Result: PASSED");
         $finish;
      end
   end

endmodule

/* testbench/armTestMem.sv */
`timescale 1ns/1ns
// Testbench memories, an instruction ROM and a data RAM that both answer in the same cycle
module armTestMem
#(
   parameter int RomWords = 64,
   parameter int RamWords = 256
)
(
   input  logic          clk,
   input  armPkg::word_t pc,
   output armPkg::word_t instr,
   input  logic          memWrite,
   input  armPkg::word_t addr,
   input  armPkg::word_t writeData,
   output armPkg::word_t readData
);
   import armPkg::*;

   localparam int RomBits = $clog2(RomWords);
   localparam int RamBits = $clog2(RamWords);

   word_t rom [RomWords];   // Contents written by the testbench
   word_t ram [RamWords];

   assign instr    = rom[pc[RomBits+1:2]];      // Word addressed
   assign readData = ram[addr[RamBits+1:2]];

   always @(posedge clk)
   begin
      if (memWrite)
         ram[addr[RamBits+1:2]] <= writeData;
   end

endmodule
